//--- all.f
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/rx_queue.sv
hdl/uart_loopback.sv
test/uart_loopback_tb.sv

//--- Makefile
# Verilator build and run of the UART loopback testbench

VERILATOR ?= verilator
TOP ?= uart_loopback_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/uart_loopback_tb.sv
`timescale 1ns/1ns

module uart_loopback_tb import uart_pkg::*;;

	localparam int CLKS_PER_BIT = 8;
	localparam bit PARITY_EN = 1'b1;
	localparam bit PARITY_ODD = 1'b0;                 // even parity
	localparam int QUEUE_DEPTH = 4;
	localparam logic [31:0] SEED = 32'h4040_2b9e;
	localparam int FRAME_BITS = DATA_WIDTH + 2 + (PARITY_EN ? 1 : 0);
	localparam int FRAME_CYC = FRAME_BITS * CLKS_PER_BIT;   // busy length of one frame
	localparam int PAR_IDX = DATA_WIDTH + 1;          // parity slot in the frame
	localparam int DRAIN_LIMIT = 64 * FRAME_CYC;

	logic clk;
	logic reset;
	logic i_tx_en;
	logic [DATA_WIDTH-1:0] i_tx_data;
	logic o_tx_busy;
	logic o_serial_out;
	logic serial_in;                                  // line after the corruption mux
	rx_word_t o_rx_word;
	logic o_rx_valid;
	logic i_rx_read;
	logic o_rx_overflow;

	logic corrupt_par;                                // invert parity of the next frame
	logic corrupt_stop;                               // pull stop of the next frame low
	logic [1:0] rd_mode;                              // 0 no reads, 1 random, 2 every cycle
	logic [31:0] rng;                                 // stimulus stream
	logic [31:0] rd_state;                            // read pulse stream
	int tx_cyc;                                       // cycle index inside the busy window
	int ov_count;                                     // overflow pulses seen
	logic [DATA_WIDTH-1:0] cur_byte;                  // byte of the frame on the line
	logic [DATA_WIDTH-1:0] tx_q[$];                   // bytes accepted by the transmitter
	rx_word_t exp_q[$];                               // words the queue should hand out
	logic par_slot;
	logic stop_slot;

	uart_loopback #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.PARITY_EN(PARITY_EN),
		.PARITY_ODD(PARITY_ODD),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.i_tx_en(i_tx_en),
		.i_tx_data(i_tx_data),
		.o_tx_busy(o_tx_busy),
		.o_serial_out(o_serial_out),
		.i_serial_in(serial_in),
		.o_rx_word(o_rx_word),
		.o_rx_valid(o_rx_valid),
		.i_rx_read(i_rx_read),
		.o_rx_overflow(o_rx_overflow)
	);

	always #2 clk = ~clk;                             // 4 ns period

	// slots follow the fixed tx timing with tx_cyc equal to k in busy cycle k
	assign par_slot = o_tx_busy && (tx_cyc / CLKS_PER_BIT == PAR_IDX);
	assign stop_slot = o_tx_busy && (tx_cyc / CLKS_PER_BIT == FRAME_BITS - 1);
	assign serial_in = (o_serial_out ^ (corrupt_par && par_slot)) & ~(corrupt_stop && stop_slot);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// parity bit the line should carry
	function automatic logic ref_parity(input logic [DATA_WIDTH-1:0] b);
		logic p;
		int i;
		p = PARITY_ODD;                               // odd starts from one
		for (i = 0; i < DATA_WIDTH; i++) begin
			p = p ^ b[i];
		end
		return p;
	endfunction

	// expected line level for bit idx of a frame carrying b
	function automatic logic frame_bit(input logic [DATA_WIDTH-1:0] b, input int idx);
		logic v;
		if (idx == 0) begin
			v = 1'b0;                                 // start
		end else if (idx <= DATA_WIDTH) begin
			v = b[idx-1];                             // data lsb first
		end else if (PARITY_EN && idx == PAR_IDX) begin
			v = ref_parity(b);
		end else begin
			v = 1'b1;                                 // stop
		end
		return v;
	endfunction

	task automatic stop_with_fail();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic report_fail(input string msg);
		$display("%s", msg);
		stop_with_fail();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			stop_with_fail();
		end
	endtask

	// hold the strobe until the transmitter takes it
	task automatic send_byte(input logic [DATA_WIDTH-1:0] data);
		int waited;
		rx_word_t exp;
		waited = 0;
		@(posedge clk);
		i_tx_en <= 1'b1;
		i_tx_data <= data;
		@(negedge clk);
		while (o_tx_busy) begin
			waited++;
			if (waited > 2 * FRAME_CYC) begin
				report_fail("transmitter stayed busy and never took the byte");
			end
			@(negedge clk);
		end
		@(posedge clk);                               // accepted on this edge
		i_tx_en <= 1'b0;
		tx_q.push_back(data);
		exp.data = data;
		exp.parity_err = corrupt_par && PARITY_EN;
		exp.frame_err = corrupt_stop;
		exp_q.push_back(exp);
	endtask

	// random strobes that land inside the busy window
	task automatic strobe_while_busy(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge clk);
			if (o_tx_busy && tx_cyc < FRAME_CYC - 2) begin
				rng = xorshift(rng);
				@(posedge clk);
				i_tx_en <= 1'b1;
				i_tx_data <= rng[DATA_WIDTH-1:0];
				@(posedge clk);
				i_tx_en <= 1'b0;
			end
		end
	endtask

	task automatic wait_tx_idle();
		int waited;
		waited = 0;
		@(negedge clk);
		while (o_tx_busy) begin
			waited++;
			if (waited > 2 * FRAME_CYC) begin
				report_fail("transmitter busy for longer than a frame");
			end
			@(negedge clk);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (exp_q.size() != 0 || o_tx_busy) begin
			waited++;
			if (waited > DRAIN_LIMIT) begin
				report_fail("expected words never came out of the receive queue");
			end
			@(negedge clk);
		end
	endtask

	// tx monitor checks bit middles and busy length on pre-edge values
	always @(posedge clk) begin
		if (reset) begin
			tx_cyc <= 0;
		end else if (o_tx_busy) begin
			if (tx_cyc == 0) begin
				if (tx_q.size() == 0) begin
					report_fail("transmitter started a frame with no byte accepted");
				end
				cur_byte = tx_q.pop_front();
			end
			if (tx_cyc % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
				check_value("o_serial_out", 32'(o_serial_out),
					32'(frame_bit(cur_byte, tx_cyc / CLKS_PER_BIT)));
			end
			tx_cyc <= tx_cyc + 1;
		end else begin
			if (tx_cyc != 0) begin
				check_value("o_tx_busy cycles", tx_cyc, FRAME_CYC);
			end
			tx_cyc <= 0;
		end
	end

	// rx side handles a dropped word before the pop
	always @(posedge clk) begin
		if (!reset) begin
			if (o_rx_overflow) begin
				if (exp_q.size() <= QUEUE_DEPTH) begin
					report_fail("overflow pulse with no word left to drop");
				end
				exp_q.delete(QUEUE_DEPTH);            // oldest word not yet queued
				ov_count++;
			end
			if (i_rx_read && o_rx_valid) begin
				if (exp_q.size() == 0) begin
					report_fail("receive queue handed out a word that was never sent");
				end
				check_value("o_rx_word", 32'(o_rx_word), 32'(exp_q.pop_front()));
			end
		end
	end

	// read pulse driver
	always @(posedge clk) begin
		if (reset) begin
			i_rx_read <= 1'b0;
		end else begin
			case (rd_mode)
				2'd1: begin
					rd_state = xorshift(rd_state);
					i_rx_read <= (rd_state[1:0] == 2'b00);  // about one cycle in four
				end
				2'd2: i_rx_read <= 1'b1;
				default: i_rx_read <= 1'b0;
			endcase
		end
	end

	initial begin
		int i;
		clk = 1'b0;
		reset = 1'b1;
		i_tx_en = 1'b0;
		i_tx_data = '0;
		i_rx_read = 1'b0;
		corrupt_par = 1'b0;
		corrupt_stop = 1'b0;
		rd_mode = 2'd0;
		ov_count = 0;
		rng = SEED;
		rd_state = SEED ^ 32'h5555_aaaa;              // second stream off the same seed
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("o_serial_out", 32'(o_serial_out), 32'd1);
		check_value("o_tx_busy", 32'(o_tx_busy), 32'd0);
		check_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
		check_value("o_rx_overflow", 32'(o_rx_overflow), 32'd0);
		// back to back frames with strobes thrown in while busy
		rd_mode <= 2'd1;
		for (i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			send_byte(rng[DATA_WIDTH-1:0]);
			rng = xorshift(rng);
			strobe_while_busy(int'(rng[1:0]) + 1);
		end
		drain();
		// stream with random gaps
		for (i = 0; i < 24; i++) begin
			rng = xorshift(rng);
			repeat (int'(rng[4:0])) @(posedge clk);
			rng = xorshift(rng);
			send_byte(rng[DATA_WIDTH-1:0]);
			if (rng[31]) begin
				strobe_while_busy(3);
			end
		end
		drain();
		// parity error, stop error, then a clean frame
		wait_tx_idle();
		corrupt_par <= 1'b1;
		rng = xorshift(rng);
		send_byte(rng[DATA_WIDTH-1:0]);
		wait_tx_idle();
		corrupt_par <= 1'b0;
		corrupt_stop <= 1'b1;
		rng = xorshift(rng);
		send_byte(rng[DATA_WIDTH-1:0]);
		wait_tx_idle();
		corrupt_stop <= 1'b0;
		repeat (2 * CLKS_PER_BIT) @(posedge clk);     // rx waits for the line to go high
		rng = xorshift(rng);
		send_byte(rng[DATA_WIDTH-1:0]);
		drain();
		check_value("overflow count", ov_count, 0);
		// fill the queue past its depth
		rd_mode <= 2'd0;
		for (i = 0; i < QUEUE_DEPTH + 2; i++) begin
			rng = xorshift(rng);
			send_byte(rng[DATA_WIDTH-1:0]);
		end
		i = 0;
		while (ov_count < 2) begin
			@(negedge clk);
			i++;
			if (i > 4 * FRAME_CYC) begin
				report_fail("second overflow pulse never came");
			end
		end
		repeat (2 * FRAME_CYC) @(negedge clk);        // no further pulse allowed
		check_value("overflow count", ov_count, 2);
		check_value("o_rx_valid", 32'(o_rx_valid), 32'd1);
		check_value("o_rx_word", 32'(o_rx_word), 32'(exp_q[0]));  // oldest shown without a read
		rd_mode <= 2'd2;
		drain();
		@(negedge clk);
		check_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
		if (exp_q.size() == 0 && tx_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			report_fail("models still hold entries at the end of the run");
		end
	end

endmodule

//--- hdl/uart_loopback.sv
`timescale 1ns/1ns

module uart_loopback import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8,            // clock cycles per serial bit
	parameter bit PARITY_EN = 1'b1,
	parameter bit PARITY_ODD = 1'b0,           // 0 even, 1 odd
	parameter int QUEUE_DEPTH = 4              // receive queue entries, power of two
) (
	input logic clk,
	input logic reset,
	input logic i_tx_en,                       // send strobe
	input logic [DATA_WIDTH-1:0] i_tx_data,
	output logic o_tx_busy,
	output logic o_serial_out,                 // transmit line
	input logic i_serial_in,                   // receive line, async
	output rx_word_t o_rx_word,                // oldest queued word
	output logic o_rx_valid,                   // queue not empty
	input logic i_rx_read,                     // pop pulse
	output logic o_rx_overflow                 // word dropped at full queue
);

	rx_word_t rx_word;                         // receiver to queue
	logic rx_word_valid;

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.PARITY_EN(PARITY_EN),
		.PARITY_ODD(PARITY_ODD)
	) uart_tx_i (
		.clk(clk),
		.reset(reset),
		.i_en(i_tx_en),
		.i_data(i_tx_data),
		.o_busy(o_tx_busy),
		.o_serial(o_serial_out)
	);

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.PARITY_EN(PARITY_EN),
		.PARITY_ODD(PARITY_ODD)
	) uart_rx_i (
		.clk(clk),
		.reset(reset),
		.i_serial(i_serial_in),
		.o_word(rx_word),
		.o_word_valid(rx_word_valid)
	);

	rx_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) rx_queue_i (
		.clk(clk),
		.reset(reset),
		.i_wr(rx_word_valid),
		.i_wr_word(rx_word),
		.i_rd(i_rx_read),
		.o_rd_word(o_rx_word),
		.o_not_empty(o_rx_valid),
		.o_overflow(o_rx_overflow)
	);

endmodule

//--- hdl/rx_queue.sv
`timescale 1ns/1ns

module rx_queue import uart_pkg::*; #(
	parameter int QUEUE_DEPTH = 4              // power of two
) (
	input logic clk,
	input logic reset,
	input logic i_wr,                          // write strobe from the receiver
	input rx_word_t i_wr_word,
	input logic i_rd,                          // pop pulse, ignored when empty
	output rx_word_t o_rd_word,                // oldest entry
	output logic o_not_empty,
	output logic o_overflow                    // pulse per dropped word
);

	localparam int PTR_W = cnt_width(QUEUE_DEPTH);

	rx_word_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;                     // occupancy, 0..QUEUE_DEPTH
	logic full;
	logic do_rd;
	logic do_wr;

	assign full = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign o_not_empty = (count != '0);
	assign do_rd = i_rd && o_not_empty;
	assign do_wr = i_wr && (!full || do_rd);   // a pop frees the slot in the same cycle
	assign o_rd_word = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;       // wraps, depth is a power of two
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;       // none, or push and pop together
			endcase
			o_overflow <= i_wr && !do_wr;      // word arrived at a full queue
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_wr_word;
		end
	end

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8,            // clock cycles per serial bit
	parameter bit PARITY_EN = 1'b1,            // parity slot expected
	parameter bit PARITY_ODD = 1'b0            // 0 even, 1 odd
) (
	input logic clk,
	input logic reset,
	input logic i_serial,                      // async line
	output rx_word_t o_word,                   // finished word
	output logic o_word_valid                  // one-cycle strobe with o_word
);

	localparam int FRAME_BITS = frame_bits(PARITY_EN);
	localparam int CNT_W = cnt_width(CLKS_PER_BIT);
	localparam int BIT_W = cnt_width(FRAME_BITS);
	localparam int HALF_BIT = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

	typedef enum logic [2:0] {
		S_IDLE,                                // hunting for a falling edge
		S_START,                               // confirm start low at its middle
		S_DATA,
		S_PARITY,
		S_STOP,
		S_WAIT_HIGH                            // after a frame error, wait for idle level
	} rx_state_t;

	rx_state_t state;
	logic [2:0] sync;                          // three-flop synchronizer
	logic line;                                // synchronized line
	logic [CNT_W-1:0] clk_cnt;                 // cycles since the last sample point
	logic [BIT_W-1:0] bit_cnt;                 // frame position, data bits are 1..DATA_WIDTH
	logic tick;                                // sample point of the current bit
	logic [DATA_WIDTH-1:0] data_sr;            // data shifted in lsb first
	logic parity_err;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '1;                        // idle level, no false start out of reset
		end else begin
			sync <= {sync[1:0], i_serial};
		end
	end

	assign line = sync[2];

	// half a bit into the start bit, a full bit for each one after
	always_comb begin
		case (state)
			S_START: tick = (clk_cnt == CNT_W'(HALF_BIT - 1));
			S_DATA, S_PARITY, S_STOP: tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
			default: tick = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			clk_cnt <= '0;
		end else if (tick || state == S_IDLE || state == S_WAIT_HIGH) begin
			clk_cnt <= '0;                     // restart timing from each sample point
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			bit_cnt <= '0;
			o_word_valid <= 1'b0;
		end else begin
			o_word_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (!line) begin
						state <= S_START;      // falling edge, line was high to get here
					end
				end
				S_START: begin
					if (tick) begin
						bit_cnt <= BIT_W'(1);
						state <= line ? S_IDLE : S_DATA;  // high again means a glitch
					end
				end
				S_DATA: begin
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_WIDTH)) begin
							state <= PARITY_EN ? S_PARITY : S_STOP;
						end
					end
				end
				S_PARITY: begin
					if (tick) begin
						state <= S_STOP;
					end
				end
				S_STOP: begin
					if (tick) begin
						o_word_valid <= 1'b1;  // word leaves the cycle after the stop sample
						state <= line ? S_IDLE : S_WAIT_HIGH;
					end
				end
				S_WAIT_HIGH: begin
					if (line) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word assembly
	always_ff @(posedge clk) begin
		if (state == S_START) begin
			parity_err <= 1'b0;                // stays clear when no parity slot
		end
		if (tick && state == S_DATA) begin
			data_sr <= {line, data_sr[DATA_WIDTH-1:1]};
		end
		if (tick && state == S_PARITY) begin
			parity_err <= (line != data_parity(data_sr, PARITY_ODD));
		end
		if (tick && state == S_STOP) begin
			o_word.data <= data_sr;
			o_word.parity_err <= parity_err;
			o_word.frame_err <= !line;         // stop must be high
		end
	end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 8,            // clock cycles per serial bit
	parameter bit PARITY_EN = 1'b1,            // parity slot present
	parameter bit PARITY_ODD = 1'b0            // 0 even, 1 odd
) (
	input logic clk,
	input logic reset,
	input logic i_en,                          // send strobe, dropped while busy
	input logic [DATA_WIDTH-1:0] i_data,       // byte taken with the strobe
	output logic o_busy,                       // high for the whole frame
	output logic o_serial                      // line, idles high
);

	localparam int FRAME_BITS = frame_bits(PARITY_EN);
	localparam int CNT_W = cnt_width(CLKS_PER_BIT);
	localparam int BIT_W = cnt_width(FRAME_BITS);

	logic [CNT_W-1:0] clk_cnt;                 // cycles spent in the current bit
	logic [BIT_W-1:0] bit_cnt;                 // position of the bit on the line
	logic [FRAME_BITS-1:0] frame;              // full frame, start bit in bit 0
	logic [FRAME_BITS-2:0] shift_reg;          // bits still to go after the one on the line
	logic accept;                              // strobe taken this cycle
	logic bit_end;                             // last cycle of the current bit
	logic last_bit;                            // current bit is the stop bit

	assign accept = i_en && !o_busy;
	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign last_bit = (bit_cnt == BIT_W'(FRAME_BITS - 1));

	// frame layout, lsb goes out first
	always_comb begin
		frame = '1;                            // stop bit and any unused slot high
		frame[0] = 1'b0;                       // start
		frame[DATA_WIDTH:1] = i_data;          // data lsb first
		if (PARITY_EN) begin
			frame[DATA_WIDTH+1] = data_parity(i_data, PARITY_ODD);
		end
	end

	// busy, bit timing and the registered line
	always_ff @(posedge clk) begin
		if (reset) begin
			o_busy <= 1'b0;
			o_serial <= 1'b1;                  // line idles high
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (accept) begin
			o_busy <= 1'b1;
			o_serial <= frame[0];              // start bit shows from the next cycle
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (o_busy) begin
			if (bit_end) begin
				clk_cnt <= '0;
				if (last_bit) begin
					o_busy <= 1'b0;            // stop bit done, free next cycle
					o_serial <= 1'b1;
				end else begin
					o_serial <= shift_reg[0];  // next bit onto the line
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// frame shifter, loaded with everything after the start bit
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= frame[FRAME_BITS-1:1];
		end else if (o_busy && bit_end) begin
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};  // fill with idle level
		end
	end

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

	localparam int DATA_WIDTH = 8;              // data bits carried by one frame

	// one finished word as the receiver hands it to the queue
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;            // received byte, lsb was first on the line
		logic parity_err;                       // parity bit disagreed with the data
		logic frame_err;                        // stop bit sampled low
	} rx_word_t;

	// start + data + optional parity + stop
	function automatic int frame_bits(input bit parity_en);
		int bits;
		bits = DATA_WIDTH + 2;                  // start and stop
		if (parity_en) begin
			bits = bits + 1;                    // parity slot between data and stop
		end
		return bits;
	endfunction

	// counter width for a modulo-n count, never below one bit
	function automatic int cnt_width(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	// parity bit to put on the line for a data word
	function automatic logic data_parity(
		input logic [DATA_WIDTH-1:0] data,
		input bit odd                           // 0 even, 1 odd
	);
		return (^data) ^ odd;                   // odd flips the even result
	endfunction

endpackage
